// File: Makefile
VERILATOR ?= verilator
TOP       ?= shooter_tb
OBJ_DIR   ?= obj_dir
VFLAGS    ?= --binary --timing --assert -j 0
FILELIST  ?= sources.f

.PHONY: sim clean

sim:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -Mdir $(OBJ_DIR) -f $(FILELIST)
	./$(OBJ_DIR)/V$(TOP)

clean:
	rm -rf $(OBJ_DIR)

// File: rtl/bullet_bank.sv
`timescale 1ns/1ps

module bullet_bank (
    input  logic                                             clk,
    input  logic                                             rstn,
    input  logic                                             restart,
    input  logic                                             fire_req,
    input  logic                                             tick,
    input  logic                                             active,
    input  shooter_pkg::coord_t                              player_x,
    input  logic [shooter_pkg::NUM_SLOTS-1:0]                bullet_kill,
    output shooter_pkg::sprite_t [shooter_pkg::NUM_SLOTS-1:0] bullets
);

    localparam int N  = shooter_pkg::NUM_SLOTS;
    localparam int IW = $clog2(N);

    logic [N-1:0]        alive;
    shooter_pkg::coord_t pos_x [N];
    shooter_pkg::coord_t pos_y [N];
    logic [N-1:0]        leaving;
    logic [IW-1:0]       free_idx;
    logic                has_free;

    // lowest dead slot wins
    always_comb begin
        has_free = 1'b0;
        free_idx = '0;
        for (int i = N - 1; i >= 0; i--) begin
            if (!alive[i]) begin
                has_free = 1'b1;
                free_idx = IW'(i);
            end
        end
    end

    // next climb would take it off the field
    always_comb begin
        for (int i = 0; i < N; i++) begin
            leaving[i] = (pos_y[i] >= shooter_pkg::FIELD_H);
        end
    end

    always_ff @(posedge clk) begin
        if (!rstn) begin
            alive <= '0;
        end else if (restart) begin
            alive <= '0;
        end else begin
            for (int i = 0; i < N; i++) begin
                if (bullet_kill[i] || (tick && active && alive[i] && leaving[i])) begin
                    alive[i] <= 1'b0;
                end
            end
            if (fire_req && has_free) begin
                alive[free_idx] <= 1'b1;
            end
        end
    end

    always_ff @(posedge clk) begin
        for (int i = 0; i < N; i++) begin
            if (tick && active && alive[i] && !leaving[i]) begin
                pos_y[i] <= pos_y[i] + 1'b1;
            end
        end
        if (fire_req && has_free) begin
            pos_x[free_idx] <= player_x + shooter_pkg::BULLET_X_OFS;
            pos_y[free_idx] <= shooter_pkg::BULLET_START_Y;
        end
    end

    always_comb begin
        for (int i = 0; i < N; i++) begin
            bullets[i].alive = alive[i];
            bullets[i].x     = pos_x[i];
            bullets[i].y     = pos_y[i];
        end
    end

endmodule

// File: rtl/collision_unit.sv
`timescale 1ns/1ps

module collision_unit (
    input  logic                                             clk,
    input  logic                                             rstn,
    input  logic                                             restart,
    input  logic                                             tick,
    input  logic                                             active,
    input  logic                                             spawn_due,
    input  shooter_pkg::coord_t                              player_x,
    input  shooter_pkg::sprite_t [shooter_pkg::NUM_SLOTS-1:0] bullets,
    input  shooter_pkg::sprite_t [shooter_pkg::NUM_SLOTS-1:0] enemies,
    output logic [shooter_pkg::NUM_SLOTS-1:0]                bullet_kill,
    output logic [shooter_pkg::NUM_SLOTS-1:0]                enemy_kill,
    output logic                                             spawn_en,
    output logic                                             player_hit,
    output shooter_pkg::score_t                              score
);

    localparam int N = shooter_pkg::NUM_SLOTS;

    shooter_pkg::phase_t phase;
    logic [N-1:0]        hit_bullet;
    logic [N-1:0]        hit_enemy;
    logic [N-1:0]        crash_enemy;
    shooter_pkg::score_t hit_cnt;
    logic                checking;

    // strict overlap on both axes
    function automatic logic boxes_overlap(
        input shooter_pkg::coord_t ax, ay, aw, ah,
        input shooter_pkg::coord_t bx, by, bw, bh
    );
        return (int'(ax) < int'(bx) + int'(bw)) && (int'(bx) < int'(ax) + int'(aw)) &&
               (int'(ay) < int'(by) + int'(bh)) && (int'(by) < int'(ay) + int'(ah));
    endfunction

    always_ff @(posedge clk) begin
        if (!rstn) begin
            phase <= shooter_pkg::IDLE;
        end else begin
            case (phase)
                shooter_pkg::IDLE:  phase <= (tick && active) ? shooter_pkg::CHECK
                                                              : shooter_pkg::IDLE;
                shooter_pkg::CHECK: phase <= shooter_pkg::SPAWN;
                default:            phase <= shooter_pkg::IDLE;
            endcase
        end
    end

    // each bullet claims the lowest free enemy it touches
    always_comb begin
        logic found;
        hit_bullet  = '0;
        hit_enemy   = '0;
        crash_enemy = '0;
        hit_cnt     = '0;
        for (int b = 0; b < N; b++) begin
            found = 1'b0;
            for (int e = 0; e < N; e++) begin
                if (!found && bullets[b].alive && enemies[e].alive && !hit_enemy[e] &&
                    boxes_overlap(bullets[b].x, bullets[b].y,
                                  shooter_pkg::BULLET_SIZE, shooter_pkg::BULLET_SIZE,
                                  enemies[e].x, enemies[e].y,
                                  shooter_pkg::ENEMY_SIZE, shooter_pkg::ENEMY_SIZE)) begin
                    found         = 1'b1;
                    hit_bullet[b] = 1'b1;
                    hit_enemy[e]  = 1'b1;
                    hit_cnt       = hit_cnt + 1'b1;
                end
            end
        end
        for (int e = 0; e < N; e++) begin
            crash_enemy[e] = enemies[e].alive && (enemies[e].y == '0 ||
                boxes_overlap(player_x, '0, shooter_pkg::PLAYER_W, shooter_pkg::ENEMY_SIZE,
                              enemies[e].x, enemies[e].y,
                              shooter_pkg::ENEMY_SIZE, shooter_pkg::ENEMY_SIZE));
        end
    end

    assign checking    = (phase == shooter_pkg::CHECK) && active;
    assign bullet_kill = checking ? hit_bullet : '0;
    assign enemy_kill  = checking ? (hit_enemy | crash_enemy) : '0;
    assign player_hit  = checking && (|crash_enemy);
    assign spawn_en    = (phase == shooter_pkg::SPAWN) && active && spawn_due;

    always_ff @(posedge clk) begin
        if (!rstn) begin
            score <= '0;
        end else if (restart) begin
            score <= '0;
        end else if (checking) begin
            score <= score + hit_cnt;
        end
    end

endmodule

// File: rtl/enemy_bank.sv
`timescale 1ns/1ps

module enemy_bank (
    input  logic                                             clk,
    input  logic                                             rstn,
    input  logic                                             restart,
    input  logic                                             tick,
    input  logic                                             active,
    input  logic                                             spawn_en,
    input  shooter_pkg::lane_t                               spawn_lane,
    input  logic [shooter_pkg::NUM_SLOTS-1:0]                enemy_kill,
    output shooter_pkg::sprite_t [shooter_pkg::NUM_SLOTS-1:0] enemies,
    output logic                                             spawn_taken
);

    localparam int N  = shooter_pkg::NUM_SLOTS;
    localparam int IW = $clog2(N);

    logic [N-1:0]        alive;
    shooter_pkg::coord_t pos_x [N];
    shooter_pkg::coord_t pos_y [N];
    logic [IW-1:0]       free_idx;
    logic                has_free;

    always_comb begin
        has_free = 1'b0;
        free_idx = '0;
        for (int i = N - 1; i >= 0; i--) begin
            if (!alive[i]) begin
                has_free = 1'b1;
                free_idx = IW'(i);
            end
        end
    end

    // a full bank leaves the spawn request pending
    assign spawn_taken = spawn_en && has_free;

    always_ff @(posedge clk) begin
        if (!rstn) begin
            alive <= '0;
        end else if (restart) begin
            alive <= '0;
        end else begin
            for (int i = 0; i < N; i++) begin
                if (enemy_kill[i]) begin
                    alive[i] <= 1'b0;
                end
            end
            if (spawn_taken) begin
                alive[free_idx] <= 1'b1;
            end
        end
    end

    always_ff @(posedge clk) begin
        for (int i = 0; i < N; i++) begin
            // stops at the bottom, the check pass removes it there
            if (tick && active && alive[i] && pos_y[i] != '0) begin
                pos_y[i] <= pos_y[i] - 1'b1;
            end
        end
        if (spawn_taken) begin
            pos_x[free_idx] <= spawn_lane * shooter_pkg::LANE_W;
            pos_y[free_idx] <= shooter_pkg::FIELD_H;
        end
    end

    always_comb begin
        for (int i = 0; i < N; i++) begin
            enemies[i].alive = alive[i];
            enemies[i].x     = pos_x[i];
            enemies[i].y     = pos_y[i];
        end
    end

endmodule

// File: rtl/game_tick.sv
`timescale 1ns/1ps

module game_tick #(
    parameter int TICK_CYCLES = 3000000,
    parameter int SPAWN_TICKS = 32
) (
    input  logic                clk,
    input  logic                rstn,
    input  logic                spawn_taken,
    input  shooter_pkg::coord_t seed_mix,
    output logic                tick,
    output logic                spawn_due,
    output shooter_pkg::lane_t  spawn_lane
);

    localparam int CW = $clog2(TICK_CYCLES + 1);
    localparam int SW = $clog2(SPAWN_TICKS + 1);

    logic [CW-1:0] cycle_cnt;
    logic [SW-1:0] tick_cnt;
    logic [9:0]    seed;

    always_ff @(posedge clk) begin
        if (!rstn) begin
            cycle_cnt <= '0;
            tick      <= 1'b0;
        end else if (cycle_cnt == CW'(TICK_CYCLES - 1)) begin
            cycle_cnt <= '0;
            tick      <= 1'b1;
        end else begin
            cycle_cnt <= cycle_cnt + 1'b1;
            tick      <= 1'b0;
        end
    end

    // spawn period and lane generator advance once per tick
    always_ff @(posedge clk) begin
        if (!rstn) begin
            tick_cnt  <= '0;
            spawn_due <= 1'b0;
            seed      <= '0;
        end else begin
            if (spawn_taken) begin
                spawn_due <= 1'b0;
            end
            if (tick) begin
                // player position stirs the sequence
                seed <= 10'((seed + 10'd13) * 10'd7 * (10'(seed_mix) + 10'd1));
                if (tick_cnt == SW'(SPAWN_TICKS - 1)) begin
                    tick_cnt  <= '0;
                    spawn_due <= 1'b1;
                end else begin
                    tick_cnt <= tick_cnt + 1'b1;
                end
            end
        end
    end

    assign spawn_lane = shooter_pkg::lane_t'(seed % 10'd5);

endmodule

// File: rtl/player_ctrl.sv
`timescale 1ns/1ps

module player_ctrl (
    input  logic                  clk,
    input  logic                  rstn,
    input  shooter_pkg::buttons_t btn,
    input  logic                  player_hit,
    output logic                  restart,
    output logic                  active,
    output logic                  fire_req,
    output logic                  playing,
    output logic                  player_alive,
    output shooter_pkg::coord_t   player_x
);

    localparam shooter_pkg::lane_t LAST_LANE = shooter_pkg::lane_t'(shooter_pkg::NUM_SLOTS - 1);

    shooter_pkg::lane_t lane;

    // start only counts when no game is in progress
    assign restart  = btn.start && (!playing || !player_alive);
    assign active   = playing && player_alive;
    assign fire_req = btn.fire && active;
    assign player_x = lane * shooter_pkg::LANE_W;

    always_ff @(posedge clk) begin
        if (!rstn) begin
            playing      <= 1'b0;
            player_alive <= 1'b1;
            lane         <= '0;
        end else if (restart) begin
            playing      <= 1'b1;
            player_alive <= 1'b1;
            lane         <= '0;
        end else if (active) begin
            if (player_hit) begin
                player_alive <= 1'b0;
            end
            // up is left, down is right, both wrap
            if (btn.up) begin
                lane <= (lane == '0) ? LAST_LANE : lane - 1'b1;
            end else if (btn.down) begin
                lane <= (lane == LAST_LANE) ? '0 : lane + 1'b1;
            end
        end
    end

endmodule

// File: rtl/shooter_pkg.sv
package shooter_pkg;

    // playfield coordinate, lane index and score widths
    typedef logic [8:0] coord_t;
    typedef logic [2:0] lane_t;
    typedef logic [9:0] score_t;

    // slots per bank, also the number of lanes
    localparam int NUM_SLOTS = 5;

    localparam coord_t FIELD_W = 9'd150;
    localparam coord_t FIELD_H = 9'd200;
    localparam coord_t LANE_W  = coord_t'(FIELD_W / NUM_SLOTS);

    // bullet launch point relative to the player
    localparam coord_t BULLET_START_Y = 9'd40;
    localparam coord_t BULLET_X_OFS   = 9'd7;

    // hit-box sizes
    localparam coord_t BULLET_SIZE = 9'd15;
    localparam coord_t ENEMY_SIZE  = 9'd30;
    localparam coord_t PLAYER_W    = 9'd26;

    // one bullet or one enemy
    typedef struct packed {
        logic   alive;
        coord_t x;
        coord_t y;
    } sprite_t;

    typedef struct packed {
        logic up;
        logic down;
        logic fire;
        logic start;
    } buttons_t;

    // pass order after each game tick
    typedef enum logic [1:0] {
        IDLE,
        CHECK,
        SPAWN
    } phase_t;

endpackage

// File: rtl/shooter_top.sv
`timescale 1ns/1ps

module shooter_top #(
    parameter int TICK_CYCLES = 3000000,
    parameter int SPAWN_TICKS = 32
) (
    input  logic                                             clk,
    input  logic                                             rstn,
    input  shooter_pkg::buttons_t                            btn,
    output logic                                             playing,
    output logic                                             player_alive,
    output shooter_pkg::coord_t                              player_x,
    output shooter_pkg::score_t                              score,
    output shooter_pkg::sprite_t [shooter_pkg::NUM_SLOTS-1:0] bullets,
    output shooter_pkg::sprite_t [shooter_pkg::NUM_SLOTS-1:0] enemies
);

    logic                                tick;
    logic                                spawn_due;
    logic                                spawn_taken;
    shooter_pkg::lane_t                  spawn_lane;
    logic                                restart;
    logic                                active;
    logic                                fire_req;
    logic [shooter_pkg::NUM_SLOTS-1:0]   bullet_kill;
    logic [shooter_pkg::NUM_SLOTS-1:0]   enemy_kill;
    logic                                spawn_en;
    logic                                player_hit;

    game_tick #(
        .TICK_CYCLES (TICK_CYCLES),
        .SPAWN_TICKS (SPAWN_TICKS)
    ) u_game_tick (
        .clk         (clk),
        .rstn        (rstn),
        .spawn_taken (spawn_taken),
        .seed_mix    (player_x),
        .tick        (tick),
        .spawn_due   (spawn_due),
        .spawn_lane  (spawn_lane)
    );

    player_ctrl u_player_ctrl (
        .clk          (clk),
        .rstn         (rstn),
        .btn          (btn),
        .player_hit   (player_hit),
        .restart      (restart),
        .active       (active),
        .fire_req     (fire_req),
        .playing      (playing),
        .player_alive (player_alive),
        .player_x     (player_x)
    );

    bullet_bank u_bullet_bank (
        .clk         (clk),
        .rstn        (rstn),
        .restart     (restart),
        .fire_req    (fire_req),
        .tick        (tick),
        .active      (active),
        .player_x    (player_x),
        .bullet_kill (bullet_kill),
        .bullets     (bullets)
    );

    enemy_bank u_enemy_bank (
        .clk         (clk),
        .rstn        (rstn),
        .restart     (restart),
        .tick        (tick),
        .active      (active),
        .spawn_en    (spawn_en),
        .spawn_lane  (spawn_lane),
        .enemy_kill  (enemy_kill),
        .enemies     (enemies),
        .spawn_taken (spawn_taken)
    );

    collision_unit u_collision_unit (
        .clk         (clk),
        .rstn        (rstn),
        .restart     (restart),
        .tick        (tick),
        .active      (active),
        .spawn_due   (spawn_due),
        .player_x    (player_x),
        .bullets     (bullets),
        .enemies     (enemies),
        .bullet_kill (bullet_kill),
        .enemy_kill  (enemy_kill),
        .spawn_en    (spawn_en),
        .player_hit  (player_hit),
        .score       (score)
    );

endmodule

// File: sources.f
rtl/shooter_pkg.sv
rtl/game_tick.sv
rtl/player_ctrl.sv
rtl/bullet_bank.sv
rtl/enemy_bank.sv
rtl/collision_unit.sv
rtl/shooter_top.sv
testbench/tb_clock.sv
testbench/shooter_assert.sv
testbench/shooter_tb.sv

// File: testbench/shooter_assert.sv
`timescale 1ns/1ps

module shooter_assert (
    input logic                                             clk,
    input logic                                             rstn,
    input logic                                             playing,
    input logic                                             restart,
    input logic                                             tick,
    input logic                                             active,
    input shooter_pkg::phase_t                              phase,
    input logic [shooter_pkg::NUM_SLOTS-1:0]                bullet_kill,
    input shooter_pkg::score_t                              score,
    input shooter_pkg::sprite_t [shooter_pkg::NUM_SLOTS-1:0] bullets,
    input shooter_pkg::sprite_t [shooter_pkg::NUM_SLOTS-1:0] enemies
);

    logic over_field;

    always_comb begin
        over_field = 1'b0;
        for (int i = 0; i < shooter_pkg::NUM_SLOTS; i++) begin
            if ((bullets[i].alive && bullets[i].y > shooter_pkg::FIELD_H) ||
                (enemies[i].alive && enemies[i].y > shooter_pkg::FIELD_H)) begin
                over_field = 1'b1;
            end
        end
    end

    // a kill comes from the check pass entered right after an active tick
    kill_in_check: assert property (@(posedge clk) disable iff (!rstn)
        (bullet_kill != '0) |-> (phase == shooter_pkg::CHECK) && $past(tick && active))
        else $error("bullet kill outside the check pass after a tick");

    slots_on_field: assert property (@(posedge clk) disable iff (!rstn) !over_field)
        else $error("live slot above the top of the field");

    // score moves after a check pass, or is cleared by a restart
    score_after_check: assert property (@(posedge clk) disable iff (!rstn)
        !$stable(score) |-> ($past(phase) == shooter_pkg::CHECK) || $past(restart))
        else $error("score changed outside a check pass");

    idle_after_reset: assert property (@(posedge clk) $past(!rstn) |-> !playing)
        else $error("playing high right after reset");

endmodule

bind shooter_top shooter_assert u_assert (
    .clk         (clk),
    .rstn        (rstn),
    .playing     (playing),
    .restart     (restart),
    .tick        (tick),
    .active      (active),
    .phase       (u_collision_unit.phase),
    .bullet_kill (bullet_kill),
    .score       (score),
    .bullets     (bullets),
    .enemies     (enemies)
);

// File: testbench/shooter_cases.txt
# operation  argument  expected
# argument is a count of presses or fires, expected is a value or count
reset     0  0
idle      0  0
start     0  0
up        1  120
down      2  30
up        1  0
down      1  30
fire      0  0
burst     6  5
climb     0  0
gameover  0  0
frozen    0  0
start     0  0
hit       0  1

// File: testbench/shooter_tb.sv
`timescale 1ns/1ps

module shooter_tb;

    localparam int N       = shooter_pkg::NUM_SLOTS;
    localparam int TIMEOUT = 3000;

    logic                               clk;
    logic                               rstn;
    shooter_pkg::buttons_t              btn;
    logic                               playing;
    logic                               player_alive;
    shooter_pkg::coord_t                player_x;
    shooter_pkg::score_t                score;
    shooter_pkg::sprite_t [N-1:0]       bullets;
    shooter_pkg::sprite_t [N-1:0]       enemies;

    tb_clock u_clock (
        .clk  (clk),
        .rstn (rstn)
    );

    shooter_top #(
        .TICK_CYCLES (4),
        .SPAWN_TICKS (8)
    ) u_dut (
        .clk          (clk),
        .rstn         (rstn),
        .btn          (btn),
        .playing      (playing),
        .player_alive (player_alive),
        .player_x     (player_x),
        .score        (score),
        .bullets      (bullets),
        .enemies      (enemies)
    );

    task automatic stop_run(input string why);
        $display("%s", why);
        $display("TESTBENCH FAILED");
        $fatal(1, "run stopped");
    endtask

    task automatic check_eq(input string name, input logic [127:0] actual,
                            input logic [127:0] expected);
        if (actual !== expected) begin
            stop_run($sformatf("error: %s is %h, expected %h", name, actual, expected));
        end
    endtask

    function automatic int count_live(input shooter_pkg::sprite_t [N-1:0] s);
        int n;
        n = 0;
        for (int i = 0; i < N; i++) begin
            n += int'(s[i].alive);
        end
        return n;
    endfunction

    function automatic int lowest_dead(input shooter_pkg::sprite_t [N-1:0] s);
        for (int i = 0; i < N; i++) begin
            if (!s[i].alive) begin
                return i;
            end
        end
        return N;
    endfunction

    // one cycle high, one cycle released
    task automatic press(input shooter_pkg::buttons_t b);
        btn = b;
        @(negedge clk);
        btn = '0;
        @(negedge clk);
    endtask

    // net one lane right if the lane buttons were honored
    task automatic press_lanes_and_fire();
        press('{up: 1'b1, default: 1'b0});
        press('{down: 1'b1, default: 1'b0});
        press('{down: 1'b1, default: 1'b0});
        press('{fire: 1'b1, default: 1'b0});
    endtask

    task automatic wait_enemy(output int idx);
        int n;
        idx = N;
        for (n = 0; n < TIMEOUT && idx == N; n++) begin
            @(negedge clk);
            for (int i = N - 1; i >= 0; i--) begin
                if (enemies[i].alive) begin
                    idx = i;
                end
            end
        end
        if (idx == N) begin
            stop_run("no enemy spawned before the timeout");
        end
    endtask

    task automatic move_to_x(input shooter_pkg::coord_t target);
        int n;
        for (n = 0; n < 20 && player_x != target && player_alive; n++) begin
            press('{down: 1'b1, default: 1'b0});
        end
        if (n == 20) begin
            stop_run("player did not reach the target lane");
        end
    endtask

    task automatic run_case(input logic [127:0] op, input int arg, input int exp);
        int                           slot;
        int                           eidx;
        int                           n;
        shooter_pkg::coord_t          px;
        shooter_pkg::score_t          score0;
        shooter_pkg::sprite_t [N-1:0] prev_b;
        shooter_pkg::sprite_t [N-1:0] prev_e;
        if (op == "reset") begin
            check_eq("playing", playing, 0);
            check_eq("player_alive", player_alive, 1);
            check_eq("score", score, 0);
            check_eq("live slots", count_live(bullets) + count_live(enemies), exp);
        end else if (op == "idle") begin
            press_lanes_and_fire();
            check_eq("player_x", player_x, 0);
            check_eq("playing", playing, 0);
            check_eq("live bullets", count_live(bullets), exp);
        end else if (op == "start") begin
            press('{start: 1'b1, default: 1'b0});
            check_eq("playing", playing, 1);
            check_eq("player_alive", player_alive, 1);
            check_eq("player_x", player_x, 0);
            check_eq("live slots", count_live(bullets) + count_live(enemies), 0);
            check_eq("score", score, exp);
        end else if (op == "up" || op == "down") begin
            repeat (arg) press('{up: op == "up", down: op == "down", default: 1'b0});
            check_eq("player_x", player_x, exp);
        end else if (op == "fire") begin
            slot = lowest_dead(bullets);
            px   = player_x;
            btn.fire = 1'b1;
            @(negedge clk);
            btn = '0;
            check_eq("fire slot", slot, exp);
            check_eq("bullet alive", bullets[slot].alive, 1);
            check_eq("bullet x", bullets[slot].x, px + 7);
            check_eq("bullet y", bullets[slot].y, 40);
        end else if (op == "burst") begin
            btn.fire = 1'b1;
            repeat (arg) @(negedge clk);
            btn = '0;
            @(negedge clk);
            check_eq("live bullets", count_live(bullets), exp);
        end else if (op == "climb") begin
            prev_b = bullets;
            score0 = score;
            for (n = 0; n < TIMEOUT && count_live(bullets) != exp; n++) begin
                @(negedge clk);
                for (int i = 0; i < N; i++) begin
                    if (prev_b[i].alive && bullets[i].alive && bullets[i].y != prev_b[i].y) begin
                        check_eq("bullet y", bullets[i].y, prev_b[i].y + 1);
                    end else if (prev_b[i].alive && !bullets[i].alive) begin
                        // leaves from the top row, or is spent on a hit
                        check_eq("bullet exit", (prev_b[i].y == 200) || (score != score0), 1);
                    end
                end
                prev_b = bullets;
                score0 = score;
            end
            if (count_live(bullets) != exp) begin
                stop_run("bullets still alive after the timeout");
            end
        end else if (op == "gameover") begin
            wait_enemy(eidx);
            move_to_x(enemies[eidx].x);
            for (n = 0; n < TIMEOUT && player_alive; n++) begin
                @(negedge clk);
            end
            check_eq("player_alive", player_alive, exp);
        end else if (op == "frozen") begin
            px     = player_x;
            score0 = score;
            prev_b = bullets;
            prev_e = enemies;
            press_lanes_and_fire();
            check_eq("player_x", player_x, px);
            check_eq("score", score, score0);
            check_eq("bullets", bullets, prev_b);
            check_eq("enemies", enemies, prev_e);
            check_eq("player_alive", player_alive, exp);
        end else if (op == "hit") begin
            wait_enemy(eidx);
            move_to_x(enemies[eidx].x);
            check_eq("player_x", player_x, enemies[eidx].x);
            score0 = score;
            slot   = lowest_dead(bullets);
            press('{fire: 1'b1, default: 1'b0});
            check_eq("bullet alive", bullets[slot].alive, 1);
            for (n = 0; n < TIMEOUT && bullets[slot].alive; n++) begin
                @(negedge clk);
            end
            if (bullets[slot].alive) begin
                stop_run("bullet never met the enemy");
            end
            check_eq("enemy alive", enemies[eidx].alive, 0);
            check_eq("score", score, score0 + exp);
        end else begin
            stop_run("unknown operation in the cases file");
        end
    endtask

    initial begin
        int          fd;
        int          n;
        int          arg;
        int          exp;
        string       line;
        logic [127:0] op;
        btn = '0;
        for (n = 0; n < 100 && rstn !== 1'b1; n++) begin
            @(negedge clk);
        end
        if (rstn !== 1'b1) begin
            stop_run("reset never released");
        end
        fd = $fopen("testbench/shooter_cases.txt", "r");
        if (fd == 0) begin
            stop_run("cannot open the cases file");
        end
        while (!$feof(fd)) begin
            if ($fgets(line, fd) != 0 && line.len() > 1 && line[0] != "#") begin
                if ($sscanf(line, "%s %d %d", op, arg, exp) == 3) begin
                    run_case(op, arg, exp);
                end
            end
        end
        $fclose(fd);
        $display("TESTBENCH PASSED");
        $finish;
    end

endmodule

// File: testbench/tb_clock.sv
`timescale 1ns/1ps

module tb_clock (
    output logic clk,
    output logic rstn
);

    initial begin
        clk = 1'b0;
        forever #5 clk = ~clk;
    end

    // reset held for four rising edges, released on a falling edge
    initial begin
        rstn = 1'b0;
        repeat (4) @(posedge clk);
        @(negedge clk);
        rstn = 1'b1;
    end

endmodule
